// ==== logic/anc_cfg.svh ====
`ifndef ANC_CFG_SVH
`define ANC_CFG_SVH

// Stream and table widths
`define ANC_DATA_W   16            // I or Q sample
`define ANC_PHASE_W  24            // Phase accumulator
`define ANC_TRIG_W   16            // Sin or cos value
`define ANC_LUT_BITS 6             // Top phase bits into the table

// Phase sequence
`define ANC_START_PH 24'h000000    // After reset, restart or wrap
`define ANC_DPH_INC  24'h040000    // One table step per sample
`define ANC_NSIG     64            // Samples per phase period

// Output scaling
`define ANC_SCALE_W  18
`define ANC_SCALE    18'sd65535
`define ANC_SHIFT    31

// Two 32-bit products summed need one more bit
`define ANC_WIDE_W   33

`endif

// ==== logic/iq_pkg.sv ====
`include "anc_cfg.svh"

package iq_pkg;

  // Narrow complex sample as it travels on the input and output streams
  typedef struct packed {
    logic signed [`ANC_DATA_W-1:0] i;   // In-phase, upper half
    logic signed [`ANC_DATA_W-1:0] q;   // Quadrature, lower half
  } iq_sample_t;

  // Mixer result before scaling and clipping
  typedef struct packed {
    logic signed [`ANC_WIDE_W-1:0] i;
    logic signed [`ANC_WIDE_W-1:0] q;
  } iq_wide_t;

endpackage

// ==== logic/phase_pkg.sv ====
`include "anc_cfg.svh"

package phase_pkg;

  typedef logic [`ANC_PHASE_W-1:0] phase_t;   // Unsigned, wraps modulo 2^W

  // Phasor pair read from the table
  typedef struct packed {
    logic signed [`ANC_TRIG_W-1:0] sin;
    logic signed [`ANC_TRIG_W-1:0] cos;
  } sin_cos_t;

endpackage

// ==== logic/anc_phase_ctrl.sv ====
`timescale 1ns/1ps
`include "anc_cfg.svh"

module anc_phase_ctrl (
  input  logic              clk,
  input  logic              i_reset,
  input  logic              i_srst,
  input  logic              i_in_valid,
  input  logic              i_in_last,
  input  logic              i_out_ready,
  output logic              o_in_ready,
  output logic              o_advance,
  output logic              o_out_valid,
  output logic              o_out_last,
  output phase_pkg::phase_t o_phase
);
  import phase_pkg::*;

  localparam int STAGES = 4;   // LUT, products, sums, scale
  localparam int CNT_W = $clog2(`ANC_NSIG);

  logic [STAGES-1:0] valid_q;
  logic [STAGES-1:0] last_q;
  logic [CNT_W-1:0]  sample_cnt;
  logic              accept;
  logic              period_end;

  // Whole pipeline moves together, so a bubble at the end frees every stage
  assign o_advance   = i_out_ready || !valid_q[STAGES-1];
  assign o_in_ready  = o_advance;
  assign accept      = i_in_valid && o_advance;
  assign period_end  = (sample_cnt == CNT_W'(`ANC_NSIG - 1));
  assign o_out_valid = valid_q[STAGES-1];
  assign o_out_last  = last_q[STAGES-1];

  // o_phase is the phase of the beat accepted on this edge
  always_ff @(posedge clk) begin
    if (i_reset || i_srst) begin
      o_phase    <= phase_t'(`ANC_START_PH);
      sample_cnt <= '0;
    end else if (accept) begin
      if (period_end) begin
        o_phase    <= phase_t'(`ANC_START_PH);   // Period done, back to start
        sample_cnt <= '0;
      end else begin
        o_phase    <= o_phase + phase_t'(`ANC_DPH_INC);
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      valid_q <= '0;
    end else if (o_advance) begin
      valid_q <= {valid_q[STAGES-2:0], i_in_valid};
    end
  end

  always_ff @(posedge clk) begin
    if (o_advance) begin
      last_q <= {last_q[STAGES-2:0], i_in_valid && i_in_last};
    end
  end

endmodule

// ==== logic/sin_cos_lut.sv ====
`timescale 1ns/1ps
`include "anc_cfg.svh"

module sin_cos_lut (
  input  logic                clk,
  input  logic                i_advance,
  input  phase_pkg::phase_t   i_phase,
  input  iq_pkg::iq_sample_t  i_sample,
  output iq_pkg::iq_sample_t  o_sample,
  output phase_pkg::sin_cos_t o_sin_cos
);
  import phase_pkg::*;

  localparam int  LUT_N  = 1 << `ANC_LUT_BITS;
  localparam real TWO_PI = 6.283185307179586;
  localparam real AMP    = real'((1 << (`ANC_TRIG_W - 1)) - 1);   // 32767

  // Round half away from zero
  function automatic logic signed [`ANC_TRIG_W-1:0] to_fixed(input real x);
    real scaled;
    scaled = x * AMP;
    if (scaled < 0.0) begin
      return `ANC_TRIG_W'($rtoi(scaled - 0.5));
    end
    return `ANC_TRIG_W'($rtoi(scaled + 0.5));
  endfunction

  function automatic sin_cos_t lut_entry(input int k);
    sin_cos_t entry;
    real      angle;
    angle     = TWO_PI * real'(k) / real'(LUT_N);
    entry.sin = to_fixed($sin(angle));
    entry.cos = to_fixed($cos(angle));
    return entry;
  endfunction

  sin_cos_t                 lut [LUT_N];
  logic [`ANC_LUT_BITS-1:0] lut_idx;

  for (genvar k = 0; k < LUT_N; k++) begin : g_lut
    localparam sin_cos_t ENTRY = lut_entry(k);   // Constant, folded at elaboration
    assign lut[k] = ENTRY;
  end

  assign lut_idx = i_phase[`ANC_PHASE_W-1 -: `ANC_LUT_BITS];

  // Sample rides along so it meets its own phasor in the mixer
  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_sin_cos <= lut[lut_idx];
      o_sample  <= i_sample;
    end
  end

endmodule

// ==== logic/complex_mixer.sv ====
`timescale 1ns/1ps
`include "anc_cfg.svh"

module complex_mixer (
  input  logic                clk,
  input  logic                i_advance,
  input  iq_pkg::iq_sample_t  i_sample,
  input  phase_pkg::sin_cos_t i_sin_cos,
  output iq_pkg::iq_wide_t    o_wide
);

  localparam int PROD_W = `ANC_DATA_W + `ANC_TRIG_W;

  logic signed [PROD_W-1:0] prod_icos;
  logic signed [PROD_W-1:0] prod_qsin;
  logic signed [PROD_W-1:0] prod_isin;
  logic signed [PROD_W-1:0] prod_qcos;

  // Stage one, four signed products
  always_ff @(posedge clk) begin
    if (i_advance) begin
      prod_icos <= i_sample.i * i_sin_cos.cos;
      prod_qsin <= i_sample.q * i_sin_cos.sin;
      prod_isin <= i_sample.i * i_sin_cos.sin;
      prod_qcos <= i_sample.q * i_sin_cos.cos;
    end
  end

  // Stage two, (i + jq)(cos + j sin)
  // Casts keep the sign, so the sums extend correctly into the extra bit
  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_wide.i <= `ANC_WIDE_W'(prod_icos) - `ANC_WIDE_W'(prod_qsin);
      o_wide.q <= `ANC_WIDE_W'(prod_isin) + `ANC_WIDE_W'(prod_qcos);
    end
  end

endmodule

// ==== logic/scale_round_clip.sv ====
`timescale 1ns/1ps
`include "anc_cfg.svh"

module scale_round_clip (
  input  logic               clk,
  input  logic               i_advance,
  input  iq_pkg::iq_wide_t   i_wide,
  output iq_pkg::iq_sample_t o_sample
);

  localparam int PROD_W = `ANC_WIDE_W + `ANC_SCALE_W;

  localparam logic signed [PROD_W-1:0] HALF_LSB = PROD_W'(1) << (`ANC_SHIFT - 1);
  localparam logic signed [PROD_W-1:0] OUT_MAX  = PROD_W'((1 << (`ANC_DATA_W - 1)) - 1);
  localparam logic signed [PROD_W-1:0] OUT_MIN  = -OUT_MAX - 1;

  // One component: scale, round half up, shift, saturate
  function automatic logic signed [`ANC_DATA_W-1:0] scale_one(
    input logic signed [`ANC_WIDE_W-1:0] x
  );
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    prod    = x * `ANC_SCALE;
    shifted = (prod + HALF_LSB) >>> `ANC_SHIFT;   // Arithmetic, floor after +half
    if (shifted > OUT_MAX) begin
      return `ANC_DATA_W'(OUT_MAX);
    end
    if (shifted < OUT_MIN) begin
      return `ANC_DATA_W'(OUT_MIN);
    end
    return `ANC_DATA_W'(shifted);
  endfunction

  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_sample.i <= scale_one(i_wide.i);
      o_sample.q <= scale_one(i_wide.q);
    end
  end

endmodule

// ==== logic/rx_anc.sv ====
`timescale 1ns/1ps

module rx_anc (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_srst,
  input  iq_pkg::iq_sample_t i_in_sample,
  input  logic               i_in_valid,
  input  logic               i_in_last,
  output logic               o_in_ready,
  output iq_pkg::iq_sample_t o_out_sample,
  output logic               o_out_valid,
  output logic               o_out_last,
  input  logic               i_out_ready,
  output phase_pkg::phase_t  o_phase
);
  import iq_pkg::*;
  import phase_pkg::*;

  logic       advance;       // Common enable for every datapath stage
  iq_sample_t lut_sample;
  sin_cos_t   lut_sin_cos;
  iq_wide_t   mix_wide;

  anc_phase_ctrl u_ctrl (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_srst      (i_srst),
    .i_in_valid  (i_in_valid),
    .i_in_last   (i_in_last),
    .i_out_ready (i_out_ready),
    .o_in_ready  (o_in_ready),
    .o_advance   (advance),
    .o_out_valid (o_out_valid),
    .o_out_last  (o_out_last),
    .o_phase     (o_phase)
  );

  sin_cos_lut u_lut (
    .clk       (clk),
    .i_advance (advance),
    .i_phase   (o_phase),
    .i_sample  (i_in_sample),
    .o_sample  (lut_sample),
    .o_sin_cos (lut_sin_cos)
  );

  complex_mixer u_mixer (
    .clk       (clk),
    .i_advance (advance),
    .i_sample  (lut_sample),
    .i_sin_cos (lut_sin_cos),
    .o_wide    (mix_wide)
  );

  scale_round_clip u_clip (
    .clk       (clk),
    .i_advance (advance),
    .i_wide    (mix_wide),
    .o_sample  (o_out_sample)
  );

endmodule

// ==== verification/rx_anc_tb.sv ====
`timescale 1ns/1ps
`include "anc_cfg.svh"

module rx_anc_tb;
  import iq_pkg::*;
  import phase_pkg::*;

  localparam int     TIMEOUT_CYCLES = 200;
  localparam int     LATENCY        = 4;      // Accepting edge to first edge that sees the beat
  localparam int     ROWS           = 16;
  localparam real    TWO_PI         = 6.283185307179586;
  localparam longint OUT_MAX        = 32767;
  localparam longint OUT_MIN        = -32768;

  typedef struct packed {
    logic signed [`ANC_DATA_W-1:0] i;
    logic signed [`ANC_DATA_W-1:0] q;
    logic                          last;
  } stim_t;

  typedef struct {
    iq_sample_t sample;
    logic       last;
    int         due;      // Cycle on which the beat should be seen in latency mode
  } expect_t;

  // Rows 8 to 11 are full scale near the diagonals and must clip
  localparam stim_t STIM [ROWS] = '{
    '{16'sd1000, 16'sd0, 1'b0},
    '{16'sd0, 16'sd1000, 1'b0},
    '{-16'sd1000, 16'sd500, 1'b0},
    '{16'sd12345, -16'sd6789, 1'b0},
    '{-16'sd20000, -16'sd20000, 1'b0},
    '{16'sd32767, 16'sd0, 1'b0},
    '{16'sd0, 16'sh8000, 1'b0},
    '{16'sd100, 16'sd200, 1'b1},
    '{16'sd32767, 16'sd32767, 1'b0},
    '{16'sh8000, 16'sh8000, 1'b0},
    '{16'sd32767, 16'sh8000, 1'b0},
    '{16'sh8000, 16'sd32767, 1'b0},
    '{16'sd1, -16'sd1, 1'b0},
    '{-16'sd5, 16'sd7, 1'b0},
    '{16'sd30000, -16'sd123, 1'b0},
    '{-16'sd1234, 16'sd4321, 1'b1}
  };

  logic       clk;
  logic       i_reset;
  logic       i_srst;
  iq_sample_t i_in_sample;
  logic       i_in_valid;
  logic       i_in_last;
  logic       o_in_ready;
  iq_sample_t o_out_sample;
  logic       o_out_valid;
  logic       o_out_last;
  logic       i_out_ready;
  phase_t     o_phase;

  logic        bp_mode;          // Random back-pressure on the output
  logic        check_latency;
  logic [31:0] lfsr_state;
  int          cycle;
  int          beat_n;           // Accepted beats since reset or restart
  int          clip_hits;
  expect_t     exp_q [$];
  expect_t     head;
  expect_t     entry;
  logic        exp_valid;

  rx_anc dut (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_srst       (i_srst),
    .i_in_sample  (i_in_sample),
    .i_in_valid   (i_in_valid),
    .i_in_last    (i_in_last),
    .o_in_ready   (o_in_ready),
    .o_out_sample (o_out_sample),
    .o_out_valid  (o_out_valid),
    .o_out_last   (o_out_last),
    .i_out_ready  (i_out_ready),
    .o_phase      (o_phase)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic phase_t model_phase(input int n);
    return phase_t'(int'(`ANC_START_PH) + (n % `ANC_NSIG) * int'(`ANC_DPH_INC));
  endfunction

  function automatic longint round_trig(input real x);
    real s;
    s = x * 32767.0;
    if (s < 0.0) begin
      return -longint'($rtoi(0.5 - s));
    end
    return longint'($rtoi(s + 0.5));
  endfunction

  function automatic longint scale_shift(input longint x);
    return (x * longint'(`ANC_SCALE) + (longint'(1) <<< (`ANC_SHIFT - 1))) >>> `ANC_SHIFT;
  endfunction

  function automatic logic signed [`ANC_DATA_W-1:0] clip_word(input longint y);
    if (y > OUT_MAX) begin
      return `ANC_DATA_W'(OUT_MAX);
    end
    if (y < OUT_MIN) begin
      return `ANC_DATA_W'(OUT_MIN);
    end
    return `ANC_DATA_W'(y);
  endfunction

  task automatic model_beat(input iq_sample_t s, input phase_t ph, output iq_sample_t r);
    int     idx;
    real    angle;
    longint c;
    longint sn;
    longint wi;
    longint wq;
    idx   = int'(ph[`ANC_PHASE_W-1 -: `ANC_LUT_BITS]);
    angle = TWO_PI * real'(idx) / real'(1 << `ANC_LUT_BITS);
    c     = round_trig($cos(angle));
    sn    = round_trig($sin(angle));
    wi    = scale_shift(longint'(s.i) * c - longint'(s.q) * sn);
    wq    = scale_shift(longint'(s.i) * sn + longint'(s.q) * c);
    if (wi > OUT_MAX || wi < OUT_MIN || wq > OUT_MAX || wq < OUT_MIN) begin
      clip_hits = clip_hits + 1;
    end
    r.i = clip_word(wi);
    r.q = clip_word(wq);
  endtask

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s stalled for %0d cycles", what, TIMEOUT_CYCLES);
    abort_run();
  endtask

  task automatic compare_sample(input string name, input iq_sample_t got, input iq_sample_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_phase(input string name, input phase_t got, input phase_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic update_ready();
    if (bp_mode) begin
      lfsr_state  = lfsr_step(lfsr_state);
      i_out_ready = lfsr_state[0];
    end else begin
      i_out_ready = 1'b1;
    end
  endtask

  // Handshake seen at the rising edge, inputs change on the falling edge
  task automatic tick(output logic accepted);
    @(posedge clk);
    accepted = i_in_valid && o_in_ready;
    @(negedge clk);
    update_ready();
  endtask

  task automatic send_beat(input stim_t row);
    logic took;
    int   waited;
    i_in_sample.i = row.i;
    i_in_sample.q = row.q;
    i_in_last     = row.last;
    i_in_valid    = 1'b1;
    waited        = 0;
    took          = 1'b0;
    while (!took) begin
      if (waited >= TIMEOUT_CYCLES) begin
        stop_on_timeout("input handshake (o_in_ready held low)");
      end
      tick(took);
      waited = waited + 1;
    end
  endtask

  task automatic soft_restart();
    logic took;
    i_in_valid = 1'b0;
    i_srst     = 1'b1;
    tick(took);
    i_srst     = 1'b0;
  endtask

  // Reference model and scoreboard
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (i_reset) begin
      beat_n = 0;
    end else begin
      if (check_latency) begin
        exp_valid = (exp_q.size() > 0) && (exp_q[0].due == cycle);
        compare_bit("o_out_valid", o_out_valid, exp_valid);
      end
      if (o_out_valid && i_out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Output beat arrived while no beat was expected");
          abort_run();
        end
        head = exp_q.pop_front();
        compare_sample("o_out_sample", o_out_sample, head.sample);
        compare_bit("o_out_last", o_out_last, head.last);
      end
      if (i_in_valid && o_in_ready) begin
        compare_phase("o_phase", o_phase, model_phase(beat_n));
        model_beat(i_in_sample, model_phase(beat_n), entry.sample);
        entry.last = i_in_last;
        entry.due  = cycle + LATENCY;
        exp_q.push_back(entry);
        beat_n = beat_n + 1;
      end
      if (i_srst) begin
        beat_n = 0;   // Beat taken on this edge kept its old phase
      end
    end
  end

  initial begin
    logic took;
    int   waited;
    i_reset       = 1'b1;
    i_srst        = 1'b0;
    i_in_sample   = '0;
    i_in_valid    = 1'b0;
    i_in_last     = 1'b0;
    i_out_ready   = 1'b0;      // In-ready then depends on an empty pipeline
    bp_mode       = 1'b0;
    check_latency = 1'b0;
    lfsr_state    = 32'hca7;
    cycle         = 0;
    beat_n        = 0;
    clip_hits     = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    compare_bit("o_out_valid", o_out_valid, 1'b0);
    compare_phase("o_phase", o_phase, phase_t'(`ANC_START_PH));
    compare_bit("o_in_ready", o_in_ready, 1'b1);
    i_out_ready = 1'b1;

    // 80 beats with the output always ready, past one phase period
    check_latency = 1'b1;
    for (int r = 0; r < 5; r++) begin
      for (int k = 0; k < ROWS; k++) begin
        send_beat(STIM[k]);
      end
    end

    check_latency = 1'b0;
    bp_mode       = 1'b1;
    for (int k = 0; k < ROWS; k++) begin
      send_beat(STIM[k]);
    end
    soft_restart();   // Beats from the round above are still in flight
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < ROWS; k++) begin
        send_beat(STIM[k]);
      end
    end

    i_in_valid = 1'b0;
    bp_mode    = 1'b0;
    waited     = 0;
    while (exp_q.size() != 0) begin
      if (waited >= TIMEOUT_CYCLES) begin
        stop_on_timeout("output handshake while draining the pipeline");
      end
      tick(took);
      waited = waited + 1;
    end

    if (clip_hits == 0) begin
      $display("The full-scale beats produced no saturated output");
      abort_run();
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== rx_anc.f ====
+incdir+logic
logic/iq_pkg.sv
logic/phase_pkg.sv
logic/anc_phase_ctrl.sv
logic/sin_cos_lut.sv
logic/complex_mixer.sv
logic/scale_round_clip.sv
logic/rx_anc.sv
verification/rx_anc_tb.sv

// ==== Makefile ====
SIM        := verilator
TOP        := rx_anc_tb
RTL_TOP    := rx_anc
FILELIST   := rx_anc.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
